/* design/hornerPkg.sv */
package hornerPkg;

	// coefficient memory index, 32 slots
	typedef logic [4:0] coefAddrT;

	typedef logic [3:0] degreeT;  // highest power, up to 15

	typedef logic [0:0] clientT;  // which engine owns the memory

	// engine control flow, one coefficient per request/release pair
	typedef enum logic [1:0] {
		stIdle,     // waiting for start
		stRequest,  // req high until ack shows up
		stRelease,  // req low until ack falls
		stFinish    // resolve carry-save pair into result
	} hornerStateT;

endpackage

/* design/coefBus.sv */
`timescale 1ns/100ps

interface coefBus import hornerPkg::*; #(
	parameter int wordWidth = 16  // coefficient width
) ();

	logic                 req;   // engine wants a word
	coefAddrT             addr;  // stable while req high
	logic                 ack;   // word is in data
	logic [wordWidth-1:0] data;  // held as long as ack high

	// requesting side
	modport engine (output req, output addr, input ack, input data);

	modport arbiter (input req, input addr, output ack, output data);

endinterface

/* design/addMopCsv.sv */
`timescale 1ns/100ps

// one column of an (m,2) compressor
module cpr #(
	parameter int depth = 4,  // input bits of this weight
	parameter int speed = 1   // 1 for tree and 0 for chain
) (
	input  logic [depth-1:0] A,   // bits of this column
	input  logic [depth-4:0] CI,  // carries from the column below
	output logic             S,
	output logic             C,
	output logic [depth-4:0] CO   // carries into the column above
);

	// queue of bits still to be added where adders eat from the front
	logic [3*depth-6:0] fifo;
	logic [depth-3:0]   coT;  // carry of every adder

	assign fifo[depth-1:0] = A;

	for (genvar i = 0; i < depth-2; i++) begin : fa
		logic [2:0] ops;  // three addends of adder i
		if (speed == 0 && i > 0) begin : chain
			// new bit, incoming carry, previous sum
			assign ops = {fifo[depth+2*i-2], fifo[depth+2*i-1], fifo[i+2]};
		end else begin : tree
			assign ops = fifo[3*i+2 -: 3];  // next three from the queue
		end
		assign fifo[depth+2*i]   = ^ops;  // sum goes to the back
		assign coT[i]            = (ops[0] & ops[1]) | (ops[0] & ops[2]) | (ops[1] & ops[2]);
		if (i < depth-3) begin : cin
			assign fifo[depth+2*i+1] = CI[i];  // then the carry from below
		end
	end

	assign CO = coT[depth-4:0];
	assign S  = fifo[3*depth-6];  // last adder's sum
	assign C  = coT[depth-3];     // last adder's carry leaves the column

endmodule

// carry-save sum of depth operands
module addMopCsv #(
	parameter int width = 8,  // operand width
	parameter int depth = 4,  // operand count, at least 4
	parameter int speed = 1
) (
	input  logic [depth*width-1:0] A,  // operand k at bits k*width
	output logic [width-1:0]       S,
	output logic [width-1:0]       C
);

	logic [depth*width-1:0]         byWeight;  // column-major copy of A
	logic [(depth-3)*(width+1)-1:0] carries;   // between neighbouring slices
	logic [width-1:0]               cT;        // column carries before the shift

	for (genvar i = 0; i < width; i++) begin : col
		for (genvar k = 0; k < depth; k++) begin : opnd
			assign byWeight[i*depth+k] = A[k*width+i];
		end
	end

	assign carries[depth-4:0] = '0;  // nothing enters the lsb column

	for (genvar i = 0; i < width; i++) begin : bits
		cpr #(
			.depth(depth),
			.speed(speed)
		) slice (
			.A (byWeight[i*depth +: depth]),
			.CI(carries[i*(depth-3) +: depth-3]),
			.S (S[i]),
			.C (cT[i]),
			.CO(carries[(i+1)*(depth-3) +: depth-3])
		);
	end

	// carry weighs one up and the top one falls outside the modulus
	assign C = {cT[width-2:0], 1'b0};

endmodule

/* design/mulAddCsvUns.sv */
`timescale 1ns/100ps

// rows of a multiplier given in carry-save form
module ppGenUns #(
	parameter int widthX = 8,  // multiplier width
	parameter int widthY = 8   // multiplicand width
) (
	input  logic [widthX-1:0]                 XS,
	input  logic [widthX-1:0]                 XC,
	input  logic [widthY-1:0]                 Y,
	output logic [widthX*(widthX+widthY)-1:0] PP  // row i at bits i*(widthX+widthY)
);

	localparam int widthP = widthX + widthY;

	logic [widthX-1:0] one;   // digit 1 at position i
	logic [widthX-1:0] two;   // digit 2 at position i
	logic [widthY+1:0] yExt;  // zero on both sides, for Y and 2Y

	assign one  = XS ^ XC;
	assign two  = XS & XC;
	assign yExt = {1'b0, Y, 1'b0};

	always_comb begin
		PP = '0;
		for (int i = 0; i < widthX; i++) begin
			for (int k = 0; k <= widthY; k++) begin
				PP[i*widthP+i+k] = (one[i] & yExt[k+1]) | (two[i] & yExt[k]);  // Y or 2Y
			end
		end
	end

endmodule

// (XS+XC)*Y + Z as a carry-save pair, mod 2^wordWidth
module mulAddCsvUns #(
	parameter int wordWidth = 16,
	parameter int speed     = 1
) (
	input  logic [wordWidth-1:0] XS,  // accumulator sum
	input  logic [wordWidth-1:0] XC,  // accumulator carry
	input  logic [wordWidth-1:0] Y,   // evaluation point
	input  logic [wordWidth-1:0] Z,   // addend row
	output logic [wordWidth-1:0] PS,
	output logic [wordWidth-1:0] PC
);

	localparam int rowWidth = 2 * wordWidth;

	logic [wordWidth*rowWidth-1:0]      pp;
	logic [(wordWidth+1)*wordWidth-1:0] rows;  // truncated products plus Z

	ppGenUns #(
		.widthX(wordWidth),
		.widthY(wordWidth)
	) ppGen (
		.XS(XS),
		.XC(XC),
		.Y (Y),
		.PP(pp)
	);

	// high half of each row never reaches the result
	for (genvar r = 0; r < wordWidth; r++) begin : trunc
		assign rows[r*wordWidth +: wordWidth] = pp[r*rowWidth +: wordWidth];
	end
	assign rows[wordWidth*wordWidth +: wordWidth] = Z;  // coefficient rides in the same tree

	addMopCsv #(
		.width(wordWidth),
		.depth(wordWidth+1),
		.speed(speed)
	) csvAdd (
		.A(rows),
		.S(PS),
		.C(PC)
	);

endmodule

/* design/coefMemory.sv */
`timescale 1ns/100ps

module coefMemory import hornerPkg::*; #(
	parameter int wordWidth = 16
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 wrEn,
	input  coefAddrT             wrAddr,
	input  logic [wordWidth-1:0] wrData,
	input  coefAddrT             rdAddr,  // from the arbiter
	output logic [wordWidth-1:0] rdData
);

	localparam int depth = 2**$bits(coefAddrT);  // one word per address

	logic [wordWidth-1:0] mem [depth];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;  // all coefficients start at zero
			end
		end else if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	// read is combinational, a write shows up one cycle later
	assign rdData = mem[rdAddr];

endmodule

/* design/coefArbiter.sv */
`timescale 1ns/100ps

module coefArbiter import hornerPkg::*; #(
	parameter int wordWidth = 16
) (
	input  logic                 clk,
	input  logic                 arstN,
	coefBus.arbiter              client0,
	coefBus.arbiter              client1,
	output coefAddrT             memAddr,
	input  logic [wordWidth-1:0] memData
);

	typedef enum logic {arbIdle, arbServe} arbStateT;

	arbStateT state;
	clientT   owner;   // current grant, kept afterwards as last served
	clientT   pick;    // winner if granting now
	clientT   sel;     // whose address goes to memory
	logic     anyReq;
	logic     ownerReq;

	assign anyReq = client0.req | client1.req;

	// round robin on a tie
	always_comb begin
		if (client0.req && client1.req) begin
			pick = ~owner;
		end else begin
			pick = client1.req;
		end
	end

	assign sel      = (state == arbIdle) ? pick : owner;
	assign memAddr  = sel ? client1.addr : client0.addr;
	assign ownerReq = owner ? client1.req : client0.req;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state       <= arbIdle;
			owner       <= 1'b1;  // client0 wins the first tie
			client0.ack <= 1'b0;
			client1.ack <= 1'b0;
		end else begin
			case (state)
				arbIdle: begin
					if (anyReq) begin
						owner <= pick;
						if (pick) begin
							client1.ack <= 1'b1;
						end else begin
							client0.ack <= 1'b1;
						end
						state <= arbServe;
					end
				end
				arbServe: begin
					// owner took its word
					if (!ownerReq) begin
						client0.ack <= 1'b0;
						client1.ack <= 1'b0;
						state       <= arbIdle;
					end
				end
				default: state <= arbIdle;
			endcase
		end
	end

	// word captured at grant, steady until ack drops
	always_ff @(posedge clk) begin
		if (state == arbIdle && anyReq) begin
			if (pick) begin
				client1.data <= memData;
			end else begin
				client0.data <= memData;
			end
		end
	end

endmodule

/* design/hornerEngine.sv */
`timescale 1ns/100ps

module hornerEngine import hornerPkg::*; #(
	parameter int wordWidth = 16,
	parameter int speed     = 1
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 start,
	input  logic [wordWidth-1:0] xVal,      // evaluation point
	input  degreeT               degree,
	input  coefAddrT             coefBase,  // highest-order coefficient
	coefBus.engine               coef,
	output logic                 busy,
	output logic                 done,
	output logic [wordWidth-1:0] result
);

	hornerStateT          state;
	logic [wordWidth-1:0] xReg;      // point latched at start
	degreeT               lastStep;  // latched degree
	degreeT               step;      // coefficient being fetched
	logic [wordWidth-1:0] accS;      // accumulator sum word
	logic [wordWidth-1:0] accC;      // accumulator carry word
	logic [wordWidth-1:0] nextS;
	logic [wordWidth-1:0] nextC;

	// acc*x + coef in one pass, no carry propagation
	mulAddCsvUns #(
		.wordWidth(wordWidth),
		.speed    (speed)
	) fusedStep (
		.XS(accS),
		.XC(accC),
		.Y (xReg),
		.Z (coef.data),
		.PS(nextS),
		.PC(nextC)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state     <= stIdle;
			busy      <= 1'b0;
			done      <= 1'b0;
			coef.req  <= 1'b0;
			coef.addr <= '0;
			step      <= '0;
			lastStep  <= '0;
			xReg      <= '0;
			accS      <= '0;
			accC      <= '0;
			result    <= '0;
		end else begin
			done <= 1'b0;  // single-cycle pulse
			case (state)
				stIdle: begin
					if (start) begin
						xReg      <= xVal;
						lastStep  <= degree;
						step      <= '0;
						coef.addr <= coefBase;
						accS      <= '0;
						accC      <= '0;
						coef.req  <= 1'b1;  // first fetch right away
						busy      <= 1'b1;
						state     <= stRequest;
					end
				end
				stRequest: begin
					if (coef.ack) begin
						accS     <= nextS;  // data valid while ack high
						accC     <= nextC;
						coef.req <= 1'b0;
						state    <= stRelease;
					end
				end
				stRelease: begin
					// next req only after ack seen low
					if (!coef.ack) begin
						if (step == lastStep) begin
							state <= stFinish;
						end else begin
							step      <= step + 1'b1;
							coef.addr <= coef.addr + 1'b1;  // wraps within 32
							coef.req  <= 1'b1;
							state     <= stRequest;
						end
					end
				end
				stFinish: begin
					result <= accS + accC;  // the one carry-propagate add
					done   <= 1'b1;
					busy   <= 1'b0;
					state  <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

/* design/hornerTop.sv */
`timescale 1ns/100ps

module hornerTop import hornerPkg::*; #(
	parameter int wordWidth = 16,
	parameter int speed     = 1  // compressor style, tree by default
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 coefWrEn,
	input  coefAddrT             coefWrAddr,
	input  logic [wordWidth-1:0] coefWrData,
	input  logic                 start_0,
	input  logic [wordWidth-1:0] xVal_0,
	input  degreeT               degree_0,
	input  coefAddrT             coefBase_0,
	output logic                 busy_0,
	output logic                 done_0,
	output logic [wordWidth-1:0] result_0,
	input  logic                 start_1,
	input  logic [wordWidth-1:0] xVal_1,
	input  degreeT               degree_1,
	input  coefAddrT             coefBase_1,
	output logic                 busy_1,
	output logic                 done_1,
	output logic [wordWidth-1:0] result_1
);

	coefAddrT             memAddr;  // granted engine's address
	logic [wordWidth-1:0] memData;

	coefBus #(.wordWidth(wordWidth)) bus0 ();
	coefBus #(.wordWidth(wordWidth)) bus1 ();

	hornerEngine #(
		.wordWidth(wordWidth),
		.speed    (speed)
	) engine0 (
		.clk     (clk),
		.arstN   (arstN),
		.start   (start_0),
		.xVal    (xVal_0),
		.degree  (degree_0),
		.coefBase(coefBase_0),
		.coef    (bus0.engine),
		.busy    (busy_0),
		.done    (done_0),
		.result  (result_0)
	);

	hornerEngine #(
		.wordWidth(wordWidth),
		.speed    (speed)
	) engine1 (
		.clk     (clk),
		.arstN   (arstN),
		.start   (start_1),
		.xVal    (xVal_1),
		.degree  (degree_1),
		.coefBase(coefBase_1),
		.coef    (bus1.engine),
		.busy    (busy_1),
		.done    (done_1),
		.result  (result_1)
	);

	coefArbiter #(.wordWidth(wordWidth)) arbiter (
		.clk    (clk),
		.arstN  (arstN),
		.client0(bus0.arbiter),
		.client1(bus1.arbiter),
		.memAddr(memAddr),
		.memData(memData)
	);

	// write port straight from the top
	coefMemory #(.wordWidth(wordWidth)) memory (
		.clk   (clk),
		.arstN (arstN),
		.wrEn  (coefWrEn),
		.wrAddr(coefWrAddr),
		.wrData(coefWrData),
		.rdAddr(memAddr),
		.rdData(memData)
	);

endmodule

/* bench/clockGen.sv */
`timescale 1ns/100ps

// free-running testbench clock
module clockGen #(
	parameter real periodNs = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2.0) clk = ~clk;  // 50% duty
	end

endmodule

/* bench/hornerBench.sv */
`timescale 1ns/100ps

module hornerBench import hornerPkg::*; ();

	localparam int wordWidth     = 16;
	localparam int timeoutCycles = 400;  // well above 16 contended fetches
	localparam int memDepth      = 32;

	typedef logic [wordWidth-1:0] wordT;

	logic     clk;
	logic     arstN;
	logic     coefWrEn;
	coefAddrT coefWrAddr;
	wordT     coefWrData;
	logic     start_0, start_1;
	wordT     xVal_0, xVal_1;
	degreeT   degree_0, degree_1;
	coefAddrT coefBase_0, coefBase_1;
	logic     busy_0, busy_1, done_0, done_1;
	wordT     result_0, result_1;

	wordT        memModel [memDepth];  // mirror of the coefficient store
	logic [31:0] lfsrState;
	int          checkCount, errCount, errsBefore, extra;
	wordT        rx0, rx1;  // evaluation points
	degreeT      rd0, rd1;
	coefAddrT    rb0, rb1;
	wordT        got0, got1, exp0, exp1;
	bit          ok;

	clockGen #(.periodNs(4.0)) clkSrc (.clk(clk));

	hornerTop #(.wordWidth(wordWidth), .speed(1)) uut (
		.clk(clk), .arstN(arstN),
		.coefWrEn(coefWrEn), .coefWrAddr(coefWrAddr), .coefWrData(coefWrData),
		.start_0(start_0), .xVal_0(xVal_0), .degree_0(degree_0), .coefBase_0(coefBase_0),
		.busy_0(busy_0), .done_0(done_0), .result_0(result_0),
		.start_1(start_1), .xVal_1(xVal_1), .degree_1(degree_1), .coefBase_1(coefBase_1),
		.busy_1(busy_1), .done_1(done_1), .result_1(result_1)
	);

	// galois lfsr shifting right with taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] drawBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrState[0]};  // one lfsr step per bit
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	// acc*x + c per step from the highest coefficient down modulo 2^16
	function automatic wordT hornerModel(input wordT x, input degreeT deg, input coefAddrT base);
		wordT acc;
		acc = '0;
		for (int i = 0; i <= deg; i++) begin
			acc = acc * x + memModel[(base + i) % memDepth];
		end
		return acc;
	endfunction

	task automatic compareWord(input string what, input wordT got, input wordT exp);
		checkCount++;
		assert (got === exp) else begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic fillMemory();
		wordT v;
		for (int a = 0; a < memDepth; a++) begin
			v = wordT'(drawBits(wordWidth));
			@(posedge clk);
			coefWrEn   <= 1'b1;
			coefWrAddr <= coefAddrT'(a);
			coefWrData <= v;
			memModel[a] = v;
		end
		@(posedge clk);
		coefWrEn <= 1'b0;  // last word readable from here on
	endtask

	task automatic startRun(input bit e0, input bit e1, input wordT x0, input degreeT d0,
			input coefAddrT b0, input wordT x1, input degreeT d1, input coefAddrT b1);
		@(posedge clk);
		if (e0) begin
			start_0 <= 1'b1;
			xVal_0 <= x0;
			degree_0 <= d0;
			coefBase_0 <= b0;
		end
		if (e1) begin
			start_1 <= 1'b1;
			xVal_1 <= x1;
			degree_1 <= d1;
			coefBase_1 <= b1;
		end
		@(posedge clk);
		start_0 <= 1'b0;  // one-cycle pulse
		start_1 <= 1'b0;
	endtask

	// waits for done on the chosen engines and grabs each result in its done cycle
	task automatic waitDone(input bit e0, input bit e1, output wordT r0, output wordT r1,
			output bit ok);
		int  cycles;
		bit  seen0, seen1;
		seen0  = !e0;
		seen1  = !e1;
		cycles = 0;
		while (!(seen0 && seen1) && cycles < timeoutCycles) begin
			@(negedge clk);  // outputs settled here
			cycles++;
			if (e0 && done_0) begin
				seen0 = 1'b1;
				r0    = result_0;
			end
			if (e1 && done_1) begin
				seen1 = 1'b1;
				r1    = result_1;
			end
		end
		ok = seen0 && seen1;
		if (!ok) begin
			$display("engine %s never raised done within %0d cycles",
				seen0 ? "1" : "0", timeoutCycles);
			errCount++;
		end
	endtask

	task automatic reportTest(input int num, input string name);
		if (errCount == errsBefore)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errCount - errsBefore);
	endtask

	initial begin
		lfsrState  = 32'd79527;
		checkCount = 0;
		errCount   = 0;
		arstN      = 1'b0;
		coefWrEn   = 1'b0;
		coefWrAddr = '0;
		coefWrData = '0;
		{start_0, start_1}       = '0;
		{xVal_0, xVal_1}         = '0;
		{degree_0, degree_1}     = '0;
		{coefBase_0, coefBase_1} = '0;
		for (int a = 0; a < memDepth; a++) begin
			memModel[a] = '0;
		end
		repeat (8) @(posedge clk);
		arstN <= 1'b1;

		errsBefore = errCount;  // reset values then a degree 0 run
		@(negedge clk);
		compareWord("busy_0 after reset", busy_0, 0);
		compareWord("busy_1 after reset", busy_1, 0);
		compareWord("done_0 after reset", done_0, 0);
		compareWord("done_1 after reset", done_1, 0);
		fillMemory();
		rx0 = wordT'(drawBits(wordWidth));
		rb0 = coefAddrT'(drawBits(5));
		startRun(1, 0, rx0, 4'd0, rb0, '0, '0, '0);
		waitDone(1, 0, got0, got1, ok);
		if (ok) compareWord("degree 0 result", got0, memModel[rb0]);
		reportTest(1, "reset and degree 0");

		errsBefore = errCount;
		for (int i = 0; i < 20; i++) begin
			rx0 = wordT'(drawBits(wordWidth));
			rd0 = degreeT'(drawBits(4));
			rb0 = coefAddrT'(drawBits(5));
			if (i == 0) begin
				rb0 = 5'd27;  // forces the wrap past entry 31
				rd0 = 4'd15;
			end
			exp0 = hornerModel(rx0, rd0, rb0);
			startRun(1, 0, rx0, rd0, rb0, '0, '0, '0);
			waitDone(1, 0, got0, got1, ok);
			if (ok) compareWord("engine 0 result", got0, exp0);
		end
		reportTest(2, "random polynomials on engine 0");

		errsBefore = errCount;
		for (int i = 0; i < 20; i++) begin
			rx0  = wordT'(drawBits(wordWidth));
			rd0  = degreeT'(drawBits(4));
			rb0  = coefAddrT'(drawBits(5));
			rx1  = wordT'(drawBits(wordWidth));
			rd1  = degreeT'(drawBits(4));
			rb1  = rb0 ^ 5'h10;  // other half of the store
			exp0 = hornerModel(rx0, rd0, rb0);
			exp1 = hornerModel(rx1, rd1, rb1);
			startRun(1, 1, rx0, rd0, rb0, rx1, rd1, rb1);
			waitDone(1, 1, got0, got1, ok);
			if (ok) begin
				compareWord("shared run engine 0", got0, exp0);
				compareWord("shared run engine 1", got1, exp1);
			end
		end
		reportTest(3, "both engines together");

		errsBefore = errCount;  // same point with new contents
		rx0 = wordT'(drawBits(wordWidth));
		rd0 = degreeT'(drawBits(4));
		rb0 = coefAddrT'(drawBits(5));
		startRun(1, 0, rx0, rd0, rb0, '0, '0, '0);
		waitDone(1, 0, got0, got1, ok);
		if (ok) compareWord("before rewrite", got0, hornerModel(rx0, rd0, rb0));
		fillMemory();
		startRun(1, 0, rx0, rd0, rb0, '0, '0, '0);
		waitDone(1, 0, got0, got1, ok);
		if (ok) compareWord("after rewrite", got0, hornerModel(rx0, rd0, rb0));
		reportTest(4, "coefficient rewrite");

		errsBefore = errCount;
		rx0 = wordT'(drawBits(wordWidth));
		rd0 = degreeT'(drawBits(3));
		rd0 = rd0 + 4'd6;  // long enough to still be busy at the second start
		rb0 = coefAddrT'(drawBits(5));
		rx1 = wordT'(drawBits(wordWidth));
		rd1 = degreeT'(drawBits(4));
		rb1 = coefAddrT'(drawBits(5));
		exp0 = hornerModel(rx0, rd0, rb0);
		startRun(1, 0, rx0, rd0, rb0, '0, '0, '0);
		@(negedge clk);
		compareWord("busy_0 during run", busy_0, 1);
		startRun(1, 0, rx1, rd1, rb1, '0, '0, '0);  // should be ignored
		waitDone(1, 0, got0, got1, ok);
		if (ok) compareWord("result with second start", got0, exp0);
		extra = 0;
		repeat (timeoutCycles) begin
			@(negedge clk);
			if (done_0) extra++;
		end
		compareWord("extra done pulses", wordT'(extra), 0);
		compareWord("busy_0 after run", busy_0, 0);
		reportTest(5, "start while busy");

		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* all.f */
design/hornerPkg.sv
design/coefBus.sv
design/addMopCsv.sv
design/mulAddCsvUns.sv
design/coefMemory.sv
design/coefArbiter.sv
design/hornerEngine.sv
design/hornerTop.sv
bench/clockGen.sv
bench/hornerBench.sv
